//--- flist.f
+incdir+src
src/rtcFieldPkg.sv
src/rtcBusPkg.sv
src/fieldCursor.sv
src/adjustBank.sv
src/commitSequencer.sv
src/rtcBusMaster.sv
src/rtcSetUnit.sv
tb/clockGen.sv
tb/rtcSlaveModel.sv
tb/rtcSetUnit_tb.sv

//--- run.sh
#!/bin/sh
# build and run the rtcSetUnit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -j 0 \
	--top-module rtcSetUnit_tb -f flist.f -o rtcSetUnit_sim

# a fatal stop exits non-zero, so the log is what decides the result
./obj_dir/rtcSetUnit_sim > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> FAIL" sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"

//--- src/adjustBank.sv
`timescale 1ns/1ps
`include "rtcSet_macros.svh"
`default_nettype none

module adjustBank
(
	input wire CLK,
	input wire reset,
	input wire rtcFieldPkg::fieldIndex cursorField,
	input wire editActive,
	input wire busy,
	input wire btnInc,
	input wire btnDec,
	input wire rtcFieldPkg::fieldIndex fieldSel,
	input wire clearField,
	output logic [`RTC_DW-1:0] netAdjust
);

	// up and down press counts per field, both wrap at 256
	logic [`RTC_DW-1:0] posCount [`RTC_FIELDS];
	logic [`RTC_DW-1:0] negCount [`RTC_FIELDS];
	logic pressEnable;

	// presses frozen while a commit runs
	assign pressEnable = editActive && !busy && (cursorField < `RTC_FIELDS);

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			for (int i = 0; i < `RTC_FIELDS; i++)
			begin
				posCount[i] <= '0;
				negCount[i] <= '0;
			end
		end
		else if (clearField)
		begin
			posCount[fieldSel] <= '0;
			negCount[fieldSel] <= '0;
		end
		else if (pressEnable)
		begin
			if (btnInc)
				posCount[cursorField] <= posCount[cursorField] + 1'b1;
			if (btnDec)
				negCount[cursorField] <= negCount[cursorField] + 1'b1;
		end
	end

	// net change for the field being committed, modulo 256
	assign netAdjust = posCount[fieldSel] - negCount[fieldSel];

endmodule

`default_nettype wire

//--- src/commitSequencer.sv
`timescale 1ns/1ps
`include "rtcSet_macros.svh"
`default_nettype none

module commitSequencer
(
	input wire CLK,
	input wire reset,
	input wire commitStart,
	input wire [`RTC_DW-1:0] netAdjust,
	input wire reqDone,
	input wire [`RTC_DW-1:0] rspData,
	output logic busy,
	output logic commitDone,
	output rtcFieldPkg::fieldIndex fieldSel,
	output logic clearField,
	output logic reqValid,
	output rtcBusPkg::busOp reqOp,
	output logic [`RTC_AW-1:0] reqAdr,
	output logic [`RTC_DW-1:0] reqData
);

	typedef enum logic [2:0]
	{
		seqIdle,
		seqRead,
		seqWrite,
		seqClear,
		seqFinish
	} seqState;

	seqState state;

	// field number to RTC register
	function automatic logic [`RTC_AW-1:0] fieldAddress(input rtcFieldPkg::fieldIndex idx);
		case (idx)
			4'd0: fieldAddress = `RTC_ADDR_CLK_SEC;
			4'd1: fieldAddress = `RTC_ADDR_CLK_MIN;
			4'd2: fieldAddress = `RTC_ADDR_CLK_HOUR;
			4'd3: fieldAddress = `RTC_ADDR_CLK_DAY;
			4'd4: fieldAddress = `RTC_ADDR_CLK_MONTH;
			4'd5: fieldAddress = `RTC_ADDR_CLK_YEAR;
			4'd6: fieldAddress = `RTC_ADDR_ALM_SEC;
			4'd7: fieldAddress = `RTC_ADDR_ALM_MIN;
			4'd8: fieldAddress = `RTC_ADDR_ALM_HOUR;
			4'd9: fieldAddress = `RTC_ADDR_ALM_DAY;
			4'd10: fieldAddress = `RTC_ADDR_TMR_SEC;
			4'd11: fieldAddress = `RTC_ADDR_TMR_MIN;
			4'd12: fieldAddress = `RTC_ADDR_TMR_HOUR;
			default: fieldAddress = `RTC_ADDR_CLK_SEC;
		endcase
	endfunction

	// operands stay put for the whole field
	assign reqAdr = fieldAddress(fieldSel);
	assign reqOp = (state == seqWrite) ? rtcBusPkg::opWrite : rtcBusPkg::opRead;

	////////////////////////////////////////////////////////////
	// read, modify, write, clear for each field
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			state <= seqIdle;
			busy <= 1'b0;
			commitDone <= 1'b0;
			clearField <= 1'b0;
			reqValid <= 1'b0;
			fieldSel <= '0;
		end
		else
		begin
			commitDone <= 1'b0;
			clearField <= 1'b0;
			case (state)
				seqIdle:
				begin
					if (commitStart)
					begin
						busy <= 1'b1;
						fieldSel <= '0;
						reqValid <= 1'b1;
						state <= seqRead;
					end
				end
				seqRead:
				begin
					// counters cannot move while busy, so netAdjust is stable here
					if (reqDone)
					begin
						reqValid <= 1'b0;
						reqData <= rspData + netAdjust;
						state <= seqWrite;
					end
				end
				seqWrite:
				begin
					// one idle cycle after the read, then hold until done
					if (reqDone)
					begin
						reqValid <= 1'b0;
						clearField <= 1'b1;
						state <= seqClear;
					end
					else
						reqValid <= 1'b1;
				end
				seqClear:
				begin
					if (fieldSel == 4'(`RTC_FIELDS - 1))
						state <= seqFinish;
					else
					begin
						fieldSel <= fieldSel + 4'd1;
						reqValid <= 1'b1;
						state <= seqRead;
					end
				end
				seqFinish:
				begin
					busy <= 1'b0;
					commitDone <= 1'b1;
					fieldSel <= '0;
					state <= seqIdle;
				end
				default:
					state <= seqIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/fieldCursor.sv
`timescale 1ns/1ps
`include "rtcSet_macros.svh"
`default_nettype none

module fieldCursor
(
	input wire CLK,
	input wire reset,
	input wire rtcFieldPkg::setMode mode,
	input wire btnLeft,
	input wire btnRight,
	output rtcFieldPkg::fieldIndex cursorField,
	output logic editActive
);

	rtcFieldPkg::setMode lastMode;
	rtcFieldPkg::fieldIndex rangeFirst;
	rtcFieldPkg::fieldIndex rangeLast;

	// contiguous field range of the active mode
	always_comb
	begin
		case (mode)
			rtcFieldPkg::modeClock:
			begin
				rangeFirst = 4'd0;
				rangeLast = 4'd5;
			end
			rtcFieldPkg::modeAlarm:
			begin
				rangeFirst = 4'd6;
				rangeLast = 4'd9;
			end
			rtcFieldPkg::modeTimer:
			begin
				rangeFirst = 4'd10;
				rangeLast = 4'(`RTC_FIELDS - 1);
			end
			default:
			begin
				rangeFirst = 4'd0;
				rangeLast = 4'd0;
			end
		endcase
	end

	assign editActive = (mode != rtcFieldPkg::modeIdle);

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			lastMode <= rtcFieldPkg::modeIdle;
			cursorField <= '0;
		end
		else
		begin
			lastMode <= mode;
			if (editActive)
			begin
				// new mode restarts at its first field
				if (mode != lastMode)
					cursorField <= rangeFirst;
				else if (btnRight && (cursorField < rangeLast))
					cursorField <= cursorField + 4'd1;
				else if (btnLeft && (cursorField > rangeFirst))
					cursorField <= cursorField - 4'd1;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/rtcBusMaster.sv
`timescale 1ns/1ps
`include "rtcSet_macros.svh"
`default_nettype none

module rtcBusMaster
(
	input wire CLK,
	input wire reset,
	input wire reqValid,
	input wire rtcBusPkg::busOp reqOp,
	input wire [`RTC_AW-1:0] reqAdr,
	input wire [`RTC_DW-1:0] reqData,
	input wire [`RTC_DW-1:0] wbDatIn,
	input wire wbAck,
	output logic reqDone,
	output logic [`RTC_DW-1:0] rspData,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output logic [`RTC_AW-1:0] wbAdr,
	output logic [`RTC_DW-1:0] wbDatOut
);

	rtcBusPkg::busState state;

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			state <= rtcBusPkg::busIdle;
			reqDone <= 1'b0;
			wbCyc <= 1'b0;
			wbStb <= 1'b0;
			wbWe <= 1'b0;
		end
		else
		begin
			reqDone <= 1'b0;
			case (state)
				rtcBusPkg::busIdle:
				begin
					if (reqValid)
					begin
						wbCyc <= 1'b1;
						wbStb <= 1'b1;
						wbWe <= (reqOp == rtcBusPkg::opWrite);
						wbAdr <= reqAdr;
						wbDatOut <= reqData;
						state <= rtcBusPkg::busActive;
					end
				end
				rtcBusPkg::busActive:
				begin
					// slave may stall as long as it likes
					if (wbAck)
					begin
						if (!wbWe)
							rspData <= wbDatIn;
						wbCyc <= 1'b0;
						wbStb <= 1'b0;
						wbWe <= 1'b0;
						reqDone <= 1'b1;
						state <= rtcBusPkg::busDone;
					end
				end
				default:
					state <= rtcBusPkg::busIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/rtcBusPkg.sv
`default_nettype none

package rtcBusPkg;

	// request kind from sequencer to bus master
	typedef enum logic
	{
		opRead = 1'b0,
		opWrite = 1'b1
	} busOp;

	// one Wishbone classic cycle per request
	typedef enum logic [1:0]
	{
		busIdle = 2'd0,
		busActive = 2'd1,
		busDone = 2'd2
	} busState;

endpackage

`default_nettype wire

//--- src/rtcFieldPkg.sv
`default_nettype none

package rtcFieldPkg;

	////////////////////////////////////////////////////////////
	// field domain types
	////////////////////////////////////////////////////////////

	// setting mode, straight from the 2-bit mode switch
	// clock owns fields 0..5, alarm 6..9, stopwatch 10..12
	typedef enum logic [1:0]
	{
		modeIdle = 2'd0,
		modeClock = 2'd1,
		modeAlarm = 2'd2,
		modeTimer = 2'd3
	} setMode;

	// field number, 0 is clock seconds and 12 is stopwatch hours
	typedef logic [3:0] fieldIndex;

endpackage

`default_nettype wire

//--- src/rtcSetUnit.sv
`timescale 1ns/1ps
`include "rtcSet_macros.svh"
`default_nettype none

module rtcSetUnit
(
	input wire CLK,
	input wire reset,
	input wire rtcFieldPkg::setMode mode,
	input wire btnLeft,
	input wire btnRight,
	input wire btnInc,
	input wire btnDec,
	input wire commitStart,
	output rtcFieldPkg::fieldIndex cursorField,
	output logic editActive,
	output logic busy,
	output logic commitDone,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output logic [`RTC_AW-1:0] wbAdr,
	output logic [`RTC_DW-1:0] wbDatOut,
	input wire [`RTC_DW-1:0] wbDatIn,
	input wire wbAck
);

	rtcFieldPkg::fieldIndex fieldSel;
	logic clearField;
	logic [`RTC_DW-1:0] netAdjust;
	logic reqValid;
	rtcBusPkg::busOp reqOp;
	logic [`RTC_AW-1:0] reqAdr;
	logic [`RTC_DW-1:0] reqData;
	logic reqDone;
	logic [`RTC_DW-1:0] rspData;

	////////////////////////////////////////////////////////////
	// front panel side
	////////////////////////////////////////////////////////////

	fieldCursor u_cursor
	(
		.CLK(CLK),
		.reset(reset),
		.mode(mode),
		.btnLeft(btnLeft),
		.btnRight(btnRight),
		.cursorField(cursorField),
		.editActive(editActive)
	);

	adjustBank u_bank
	(
		.CLK(CLK),
		.reset(reset),
		.cursorField(cursorField),
		.editActive(editActive),
		.busy(busy),
		.btnInc(btnInc),
		.btnDec(btnDec),
		.fieldSel(fieldSel),
		.clearField(clearField),
		.netAdjust(netAdjust)
	);

	////////////////////////////////////////////////////////////
	// write-back to the RTC chip
	////////////////////////////////////////////////////////////

	commitSequencer u_seq
	(
		.CLK(CLK),
		.reset(reset),
		.commitStart(commitStart),
		.netAdjust(netAdjust),
		.reqDone(reqDone),
		.rspData(rspData),
		.busy(busy),
		.commitDone(commitDone),
		.fieldSel(fieldSel),
		.clearField(clearField),
		.reqValid(reqValid),
		.reqOp(reqOp),
		.reqAdr(reqAdr),
		.reqData(reqData)
	);

	rtcBusMaster u_bus
	(
		.CLK(CLK),
		.reset(reset),
		.reqValid(reqValid),
		.reqOp(reqOp),
		.reqAdr(reqAdr),
		.reqData(reqData),
		.wbDatIn(wbDatIn),
		.wbAck(wbAck),
		.reqDone(reqDone),
		.rspData(rspData),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatOut(wbDatOut)
	);

endmodule

`default_nettype wire

//--- src/rtcSet_macros.svh
`default_nettype none
`ifndef RTC_SET_MACROS_SVH
`define RTC_SET_MACROS_SVH

// field count and bus widths
`define RTC_FIELDS 13
`define RTC_DW 8
`define RTC_AW 8

// clock registers, year sits apart from the rest
`define RTC_ADDR_CLK_SEC 8'h20
`define RTC_ADDR_CLK_MIN 8'h21
`define RTC_ADDR_CLK_HOUR 8'h22
`define RTC_ADDR_CLK_DAY 8'h23
`define RTC_ADDR_CLK_MONTH 8'h24
`define RTC_ADDR_CLK_YEAR 8'h26

// alarm registers
`define RTC_ADDR_ALM_SEC 8'h31
`define RTC_ADDR_ALM_MIN 8'h32
`define RTC_ADDR_ALM_HOUR 8'h33
`define RTC_ADDR_ALM_DAY 8'h34

// stopwatch registers
`define RTC_ADDR_TMR_SEC 8'h41
`define RTC_ADDR_TMR_MIN 8'h42
`define RTC_ADDR_TMR_HOUR 8'h43

`endif
`default_nettype wire

//--- tb/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen
#(
	parameter int periodNs = 10,
	parameter int resetCycles = 5
)
(
	output logic CLK,
	output logic reset
);

	initial
	begin
		CLK = 1'b0;
		forever
			#(periodNs / 2) CLK = ~CLK;
	end

	// reset released just after the last reset edge
	initial
	begin
		reset = 1'b1;
		repeat (resetCycles)
			@(posedge CLK);
		#1;
		reset = 1'b0;
	end

endmodule

`default_nettype wire

//--- tb/rtcSetUnit_tb.sv
`timescale 1ns/1ps
`include "rtcSet_macros.svh"
`default_nettype none

module rtcSetUnit_tb;

	localparam int maxStall = 8;
	localparam int numCommits = 10;
	// worst case per commit with two bus cycles and a clear per field
	localparam int commitCycles = `RTC_FIELDS * (2 * (maxStall + 6) + 1);
	localparam int watchdogCycles = 4 * (numCommits * commitCycles + 1500);

	typedef enum logic [1:0]
	{
		keyLeft,
		keyRight,
		keyInc,
		keyDec
	} panelKey;

	logic CLK;
	logic reset;
	rtcFieldPkg::setMode mode;
	logic btnLeft;
	logic btnRight;
	logic btnInc;
	logic btnDec;
	logic commitStart;
	rtcFieldPkg::fieldIndex cursorField;
	logic editActive;
	logic busy;
	logic commitDone;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [`RTC_AW-1:0] wbAdr;
	logic [`RTC_DW-1:0] wbDatOut;
	logic [`RTC_DW-1:0] wbDatIn;
	logic wbAck;
	logic [3:0] stallMax;
	logic loadEn;
	logic [`RTC_AW-1:0] loadAdr;
	logic [`RTC_DW-1:0] loadData;

	// reference model of the chip and the press counters
	logic [`RTC_DW-1:0] expMap [256];
	logic [`RTC_DW-1:0] posModel [`RTC_FIELDS];
	logic [`RTC_DW-1:0] negModel [`RTC_FIELDS];
	logic [31:0] lcgState;
	int doneCount;

	// open Wishbone cycle and the request it started with
	logic busOpen;
	logic heldWe;
	logic [`RTC_AW-1:0] heldAdr;
	logic [`RTC_DW-1:0] heldDat;

	clockGen u_clock
	(
		.CLK(CLK),
		.reset(reset)
	);

	rtcSetUnit u_dut
	(
		.CLK(CLK),
		.reset(reset),
		.mode(mode),
		.btnLeft(btnLeft),
		.btnRight(btnRight),
		.btnInc(btnInc),
		.btnDec(btnDec),
		.commitStart(commitStart),
		.cursorField(cursorField),
		.editActive(editActive),
		.busy(busy),
		.commitDone(commitDone),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatOut(wbDatOut),
		.wbDatIn(wbDatIn),
		.wbAck(wbAck)
	);

	rtcSlaveModel u_slave
	(
		.CLK(CLK),
		.reset(reset),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatWrite(wbDatOut),
		.wbDatRead(wbDatIn),
		.wbAck(wbAck),
		.stallMax(stallMax),
		.loadEn(loadEn),
		.loadAdr(loadAdr),
		.loadData(loadData)
	);

	always @(posedge CLK)
	begin
		if (reset)
			doneCount <= 0;
		else if (commitDone)
			doneCount <= doneCount + 1;
	end

	// master holds its request steady until the slave acknowledges
	always @(posedge CLK)
	begin
		if (reset)
			busOpen <= 1'b0;
		else
		begin
			if (busOpen)
			begin
				checkBit("busHold", "wbCyc", 1'b1, wbCyc);
				checkBit("busHold", "wbStb", 1'b1, wbStb);
				checkBit("busHold", "wbWe", heldWe, wbWe);
				checkByte("busHold", "wbAdr", heldAdr, wbAdr);
				checkByte("busHold", "wbDatOut", heldDat, wbDatOut);
			end
			busOpen <= wbCyc && !wbAck;
			heldWe <= wbWe;
			heldAdr <= wbAdr;
			heldDat <= wbDatOut;
		end
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic checkField(input string testName, input string what,
		input rtcFieldPkg::fieldIndex expected, input rtcFieldPkg::fieldIndex actual);
		if (actual !== expected)
			reportFailure($sformatf("Mismatch in %s, %s: expected %0d, actual %0d",
				testName, what, expected, actual));
	endtask

	task automatic checkByte(input string testName, input string what,
		input logic [`RTC_DW-1:0] expected, input logic [`RTC_DW-1:0] actual);
		if (actual !== expected)
			reportFailure($sformatf("Mismatch in %s, %s: expected 0x%02h, actual 0x%02h",
				testName, what, expected, actual));
	endtask

	task automatic checkBit(input string testName, input string what,
		input logic expected, input logic actual);
		if (actual !== expected)
			reportFailure($sformatf("Mismatch in %s, %s: expected %b, actual %b",
				testName, what, expected, actual));
	endtask

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// register map of the chip
	function automatic logic [`RTC_AW-1:0] fieldAddr(input rtcFieldPkg::fieldIndex f);
		case (f)
			4'd0: return `RTC_ADDR_CLK_SEC;
			4'd1: return `RTC_ADDR_CLK_MIN;
			4'd2: return `RTC_ADDR_CLK_HOUR;
			4'd3: return `RTC_ADDR_CLK_DAY;
			4'd4: return `RTC_ADDR_CLK_MONTH;
			4'd5: return `RTC_ADDR_CLK_YEAR;
			4'd6: return `RTC_ADDR_ALM_SEC;
			4'd7: return `RTC_ADDR_ALM_MIN;
			4'd8: return `RTC_ADDR_ALM_HOUR;
			4'd9: return `RTC_ADDR_ALM_DAY;
			4'd10: return `RTC_ADDR_TMR_SEC;
			4'd11: return `RTC_ADDR_TMR_MIN;
			default: return `RTC_ADDR_TMR_HOUR;
		endcase
	endfunction

	function automatic rtcFieldPkg::setMode fieldMode(input rtcFieldPkg::fieldIndex f);
		if (f < 4'd6)
			return rtcFieldPkg::modeClock;
		else if (f < 4'd10)
			return rtcFieldPkg::modeAlarm;
		return rtcFieldPkg::modeTimer;
	endfunction

	function automatic rtcFieldPkg::fieldIndex modeFirst(input rtcFieldPkg::setMode m);
		case (m)
			rtcFieldPkg::modeAlarm: return 4'd6;
			rtcFieldPkg::modeTimer: return 4'd10;
			default: return 4'd0;
		endcase
	endfunction

	function automatic rtcFieldPkg::fieldIndex modeLast(input rtcFieldPkg::setMode m);
		case (m)
			rtcFieldPkg::modeAlarm: return 4'd9;
			rtcFieldPkg::modeTimer: return 4'd12;
			default: return 4'd5;
		endcase
	endfunction

	task automatic tick();
		@(posedge CLK);
		#1;
	endtask

	// one-cycle pulse followed by a quiet cycle
	task automatic pressKey(input panelKey k);
		case (k)
			keyLeft: btnLeft = 1'b1;
			keyRight: btnRight = 1'b1;
			keyInc: btnInc = 1'b1;
			default: btnDec = 1'b1;
		endcase
		tick();
		btnLeft = 1'b0;
		btnRight = 1'b0;
		btnInc = 1'b0;
		btnDec = 1'b0;
		tick();
	endtask

	// via idle so the cursor restarts at the range start
	task automatic enterMode(input rtcFieldPkg::setMode m);
		mode = rtcFieldPkg::modeIdle;
		tick();
		mode = m;
		tick();
	endtask

	task automatic selectField(input rtcFieldPkg::fieldIndex f);
		enterMode(fieldMode(f));
		repeat (f - modeFirst(fieldMode(f)))
			pressKey(keyRight);
		checkField("selectField", "cursorField", f, cursorField);
	endtask

	task automatic addPresses(input rtcFieldPkg::fieldIndex f, input int incs, input int decs);
		selectField(f);
		repeat (incs)
		begin
			pressKey(keyInc);
			posModel[f] = posModel[f] + 8'd1;
		end
		repeat (decs)
		begin
			pressKey(keyDec);
			negModel[f] = negModel[f] + 8'd1;
		end
	endtask

	task automatic applyCommitModel();
		logic [`RTC_AW-1:0] a;
		for (int f = 0; f < `RTC_FIELDS; f++)
		begin
			a = fieldAddr(4'(f));
			expMap[a] = expMap[a] + posModel[f] - negModel[f];
			posModel[f] = 8'd0;
			negModel[f] = 8'd0;
		end
	endtask

	task automatic checkMap(input string testName);
		for (int a = 0; a < 256; a++)
			checkByte(testName, $sformatf("register 0x%02h", a), expMap[a], u_slave.regMap[a]);
	endtask

	// disturb pokes buttons and commitStart while the commit runs
	task automatic commitAndWait(input string testName, input logic disturb);
		int cycles;
		cycles = 0;
		commitStart = 1'b1;
		tick();
		commitStart = 1'b0;
		while (!commitDone)
		begin
			checkBit(testName, "busy during commit", 1'b1, busy);
			btnInc = disturb && cycles[1];
			btnDec = disturb && cycles[2];
			commitStart = disturb && (cycles % 40 == 20);
			tick();
			cycles++;
			if (cycles > commitCycles)
				reportFailure($sformatf("%s: commitDone did not arrive within %0d cycles",
					testName, commitCycles));
		end
		btnInc = 1'b0;
		btnDec = 1'b0;
		commitStart = 1'b0;
		checkBit(testName, "busy with commitDone", 1'b0, busy);
		applyCommitModel();
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task automatic resetState();
		checkBit("resetState", "wbCyc", 1'b0, wbCyc);
		checkBit("resetState", "wbStb", 1'b0, wbStb);
		checkBit("resetState", "wbWe", 1'b0, wbWe);
		checkBit("resetState", "busy", 1'b0, busy);
		checkBit("resetState", "commitDone", 1'b0, commitDone);
		checkBit("resetState", "editActive", 1'b0, editActive);
		checkField("resetState", "cursorField", 4'd0, cursorField);
	endtask

	task automatic cursorRanges();
		rtcFieldPkg::setMode m;
		for (int i = 1; i < 4; i++)
		begin
			m = rtcFieldPkg::setMode'(2'(i));
			enterMode(m);
			checkBit("cursorRanges", "editActive", 1'b1, editActive);
			checkField("cursorRanges", "range start", modeFirst(m), cursorField);
			repeat (8)
				pressKey(keyRight);
			checkField("cursorRanges", "upper clamp", modeLast(m), cursorField);
			repeat (8)
				pressKey(keyLeft);
			checkField("cursorRanges", "lower clamp", modeFirst(m), cursorField);
		end
		mode = rtcFieldPkg::modeIdle;
		tick();
		checkBit("cursorRanges", "editActive in idle", 1'b0, editActive);
	endtask

	task automatic preloadMap();
		logic [`RTC_DW-1:0] v;
		for (int a = 0; a < 256; a++)
		begin
			v = 8'(nextRandom() >> 24);
			expMap[a] = v;
			loadEn = 1'b1;
			loadAdr = 8'(a);
			loadData = v;
			tick();
		end
		loadEn = 1'b0;
	endtask

	task automatic basicCommit();
		addPresses(4'd0, 3, 0);
		addPresses(4'd5, 2, 7);
		addPresses(4'd7, 0, 1);
		addPresses(4'd12, 4, 2);
		commitAndWait("basicCommit", 1'b0);
		checkMap("basicCommit");
	endtask

	task automatic clearAfterCommit();
		commitAndWait("clearAfterCommit", 1'b0);
		checkMap("clearAfterCommit");
	endtask

	// 300 presses wrap to a net of 44
	task automatic wrapAround();
		logic [`RTC_DW-1:0] oldValue;
		oldValue = expMap[fieldAddr(4'd3)];
		addPresses(4'd3, 300, 0);
		commitAndWait("wrapAround", 1'b0);
		checkByte("wrapAround", "clock day register", oldValue + 8'd44,
			u_slave.regMap[fieldAddr(4'd3)]);
		checkMap("wrapAround");
	endtask

	task automatic pressWhileBusy();
		int doneBefore;
		addPresses(4'd9, 2, 0);
		doneBefore = doneCount;
		commitAndWait("pressWhileBusy", 1'b1);
		repeat (10)
		begin
			tick();
			checkBit("pressWhileBusy", "busy after commit", 1'b0, busy);
		end
		checkByte("pressWhileBusy", "commitDone count", 8'(doneBefore + 1), 8'(doneCount));
		checkMap("pressWhileBusy");
	endtask

	task automatic randomStalls();
		rtcFieldPkg::fieldIndex f;
		stallMax = 4'(maxStall);
		for (int round = 0; round < 3; round++)
		begin
			for (int k = 0; k < 3; k++)
			begin
				f = 4'((nextRandom() >> 16) % 32'd13);
				addPresses(f, int'((nextRandom() >> 16) % 32'd5),
					int'((nextRandom() >> 16) % 32'd5));
			end
			commitAndWait("randomStalls", 1'b0);
			checkMap("randomStalls");
		end
		stallMax = 4'd0;
	endtask

	////////////////////////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////////////////////////

	initial
	begin
		mode = rtcFieldPkg::modeIdle;
		btnLeft = 1'b0;
		btnRight = 1'b0;
		btnInc = 1'b0;
		btnDec = 1'b0;
		commitStart = 1'b0;
		stallMax = 4'd0;
		loadEn = 1'b0;
		loadAdr = '0;
		loadData = '0;
		lcgState = 32'h6035_3af3;
		for (int f = 0; f < `RTC_FIELDS; f++)
		begin
			posModel[f] = 8'd0;
			negModel[f] = 8'd0;
		end
		@(negedge reset);
		tick();
		resetState();
		cursorRanges();
		preloadMap();
		basicCommit();
		clearAfterCommit();
		wrapAround();
		pressWhileBusy();
		randomStalls();
		$display(">>> PASS");
		$finish;
	end

	initial
	begin
		repeat (watchdogCycles)
			@(posedge CLK);
		reportFailure($sformatf("timeout: tests did not finish within %0d cycles",
			watchdogCycles));
	end

endmodule

`default_nettype wire

//--- tb/rtcSlaveModel.sv
`timescale 1ns/1ps
`include "rtcSet_macros.svh"
`default_nettype none

module rtcSlaveModel
#(
	parameter logic [31:0] seed = 32'h6035_3af3
)
(
	input wire CLK,
	input wire reset,
	input wire wbCyc,
	input wire wbStb,
	input wire wbWe,
	input wire [`RTC_AW-1:0] wbAdr,
	input wire [`RTC_DW-1:0] wbDatWrite,
	output logic [`RTC_DW-1:0] wbDatRead,
	output logic wbAck,
	input wire [3:0] stallMax,
	input wire loadEn,
	input wire [`RTC_AW-1:0] loadAdr,
	input wire [`RTC_DW-1:0] loadData
);

	// full 256-byte register space of the RTC chip
	logic [`RTC_DW-1:0] regMap [256];
	logic [31:0] lcgState;
	logic pending;
	logic [3:0] waitCount;

	assign wbDatRead = regMap[wbAdr];

	always @(posedge CLK)
	begin
		if (loadEn)
			regMap[loadAdr] <= loadData;
		if (reset)
		begin
			wbAck <= 1'b0;
			pending <= 1'b0;
			waitCount <= 4'd0;
			lcgState <= seed;
		end
		else
		begin
			wbAck <= 1'b0;
			if (wbCyc && wbStb && !wbAck)
			begin
				if (!pending)
				begin
					// new cycle, draw its stall length
					pending <= 1'b1;
					waitCount <= 4'(({1'b0, lcgState[27:24]}) % ({1'b0, stallMax} + 5'd1));
					lcgState <= lcgState * 32'd1664525 + 32'd1013904223;
				end
				else if (waitCount == 4'd0)
				begin
					pending <= 1'b0;
					wbAck <= 1'b1;
					if (wbWe)
						regMap[wbAdr] <= wbDatWrite;
				end
				else
					waitCount <= waitCount - 4'd1;
			end
		end
	end

endmodule

`default_nettype wire
